/* hdl/csr_pkg.sv */
// shared CSR numbers, field positions, codes and types for every module of the CSR file
package csr_pkg;

    typedef logic [13:0] csr_num_t;   // CSR register number
    typedef logic [31:0] csr_data_t;  // data or write mask word
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;   // pending / enable vector

    // decoded register select, carried on the internal write bus
    typedef enum logic [3:0] {
        SEL_NONE, SEL_CRMD, SEL_PRMD, SEL_ECFG, SEL_ESTAT, SEL_ERA, SEL_BADV,
        SEL_EENTRY, SEL_SAVE0, SEL_SAVE1, SEL_SAVE2, SEL_SAVE3,
        SEL_TCFG, SEL_TVAL, SEL_TICLR
    } csr_sel_t;

    // register numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;  // fetch address error

    localparam int_vec_t  ECFG_LIE_MASK = 13'h1bff;       // bit 10 reserved
    localparam csr_data_t TIMER_IDLE    = 32'hffff_ffff;  // counter stopped

    // field positions, low bit of each field
    localparam int CRMD_PLV      = 0;
    localparam int CRMD_IE       = 2;
    localparam int PRMD_PPLV     = 0;
    localparam int PRMD_PIE      = 2;
    localparam int EENTRY_VA     = 6;
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TCFG_INITV    = 2;
    localparam int TICLR_CLR     = 0;

    // masked bits come from value, the rest keep the old word
    function automatic csr_data_t masked_merge(csr_data_t old_val, csr_data_t mask,
                                               csr_data_t value);
        return (mask & value) | (~mask & old_val);
    endfunction

endpackage

/* hdl/csr_bus_if.sv */
// internal write bus from the access decoder to the parallel register blocks
interface csr_bus_if;

    logic              we;      // write strobe, one per accepted write
    csr_pkg::csr_sel_t sel;     // decoded target register
    csr_pkg::csr_data_t wmask;
    csr_pkg::csr_data_t wvalue;

    modport decoder (
        output we,
        output sel,
        output wmask,
        output wvalue
    );

    modport target (
        input we,
        input sel,
        input wmask,
        input wvalue
    );

endinterface

/* hdl/csr_access.sv */
// decodes the CSR number once, drives the write bus and muxes the read images back out
module csr_access (
    input  csr_pkg::csr_num_t  csr_num,
    input  logic               csr_we,
    input  csr_pkg::csr_data_t csr_wmask,
    input  csr_pkg::csr_data_t csr_wvalue,
    input  csr_pkg::csr_data_t crmd_rd,
    input  csr_pkg::csr_data_t prmd_rd,
    input  csr_pkg::csr_data_t estat_rd,
    input  csr_pkg::csr_data_t era_rd,
    input  csr_pkg::csr_data_t badv_rd,
    input  csr_pkg::csr_data_t eentry_rd,
    input  csr_pkg::csr_data_t ecfg_rd,
    input  csr_pkg::csr_data_t tcfg_rd,
    input  csr_pkg::csr_data_t tval_rd,
    input  csr_pkg::csr_data_t save0_rd,
    input  csr_pkg::csr_data_t save1_rd,
    input  csr_pkg::csr_data_t save2_rd,
    input  csr_pkg::csr_data_t save3_rd,
    output csr_pkg::csr_data_t csr_rvalue,
    csr_bus_if.decoder         bus
);
    csr_pkg::csr_sel_t sel;

    always_comb begin
        case (csr_num)
            csr_pkg::CSR_CRMD:   sel = csr_pkg::SEL_CRMD;
            csr_pkg::CSR_PRMD:   sel = csr_pkg::SEL_PRMD;
            csr_pkg::CSR_ECFG:   sel = csr_pkg::SEL_ECFG;
            csr_pkg::CSR_ESTAT:  sel = csr_pkg::SEL_ESTAT;
            csr_pkg::CSR_ERA:    sel = csr_pkg::SEL_ERA;
            csr_pkg::CSR_BADV:   sel = csr_pkg::SEL_BADV;
            csr_pkg::CSR_EENTRY: sel = csr_pkg::SEL_EENTRY;
            csr_pkg::CSR_SAVE0:  sel = csr_pkg::SEL_SAVE0;
            csr_pkg::CSR_SAVE1:  sel = csr_pkg::SEL_SAVE1;
            csr_pkg::CSR_SAVE2:  sel = csr_pkg::SEL_SAVE2;
            csr_pkg::CSR_SAVE3:  sel = csr_pkg::SEL_SAVE3;
            csr_pkg::CSR_TCFG:   sel = csr_pkg::SEL_TCFG;
            csr_pkg::CSR_TVAL:   sel = csr_pkg::SEL_TVAL;
            csr_pkg::CSR_TICLR:  sel = csr_pkg::SEL_TICLR;
            default:             sel = csr_pkg::SEL_NONE;
        endcase
    end

    assign bus.we     = csr_we;
    assign bus.sel    = sel;
    assign bus.wmask  = csr_wmask;
    assign bus.wvalue = csr_wvalue;

    always_comb begin
        case (sel)
            csr_pkg::SEL_CRMD:   csr_rvalue = crmd_rd;
            csr_pkg::SEL_PRMD:   csr_rvalue = prmd_rd;
            csr_pkg::SEL_ECFG:   csr_rvalue = ecfg_rd;
            csr_pkg::SEL_ESTAT:  csr_rvalue = estat_rd;
            csr_pkg::SEL_ERA:    csr_rvalue = era_rd;
            csr_pkg::SEL_BADV:   csr_rvalue = badv_rd;
            csr_pkg::SEL_EENTRY: csr_rvalue = eentry_rd;
            csr_pkg::SEL_SAVE0:  csr_rvalue = save0_rd;
            csr_pkg::SEL_SAVE1:  csr_rvalue = save1_rd;
            csr_pkg::SEL_SAVE2:  csr_rvalue = save2_rd;
            csr_pkg::SEL_SAVE3:  csr_rvalue = save3_rd;
            csr_pkg::SEL_TCFG:   csr_rvalue = tcfg_rd;
            csr_pkg::SEL_TVAL:   csr_rvalue = tval_rd;
            default:             csr_rvalue = '0;  // ticlr is write only
        endcase
    end

endmodule

/* hdl/csr_trap_regs.sv */
// privilege and trap state: CRMD, PRMD, ESTAT codes, ERA, BADV, EENTRY with entry and ertn
module csr_trap_regs (
    input  logic                clk,
    input  logic                resetn,
    input  logic                wb_ex,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_data_t  wb_pc,
    input  csr_pkg::csr_data_t  wb_vaddr,
    input  logic                ertn_flush,
    csr_bus_if.target           bus,
    input  csr_pkg::int_vec_t   est_is,
    output logic                crmd_ie,
    output csr_pkg::csr_data_t  crmd_rd,
    output csr_pkg::csr_data_t  prmd_rd,
    output csr_pkg::csr_data_t  estat_rd,
    output csr_pkg::csr_data_t  era_rd,
    output csr_pkg::csr_data_t  badv_rd,
    output csr_pkg::csr_data_t  eentry_rd
);
    csr_pkg::plv_t                  crmd_plv;
    csr_pkg::plv_t                  prmd_pplv;
    logic                           prmd_pie;
    csr_pkg::ecode_t                estat_ecode;
    csr_pkg::esubcode_t             estat_esubcode;
    csr_pkg::csr_data_t             era_pc;
    csr_pkg::csr_data_t             badv_vaddr;
    logic [31:csr_pkg::EENTRY_VA]   eentry_va;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_era;
    logic wr_eentry;
    logic ex_addr_err;
    csr_pkg::csr_data_t crmd_wr;
    csr_pkg::csr_data_t prmd_wr;
    csr_pkg::csr_data_t era_wr;
    csr_pkg::csr_data_t eentry_wr;

    assign wr_crmd   = bus.we && bus.sel == csr_pkg::SEL_CRMD;
    assign wr_prmd   = bus.we && bus.sel == csr_pkg::SEL_PRMD;
    assign wr_era    = bus.we && bus.sel == csr_pkg::SEL_ERA;
    assign wr_eentry = bus.we && bus.sel == csr_pkg::SEL_EENTRY;

    // merged words, sliced into the fields below
    assign crmd_wr   = csr_pkg::masked_merge(crmd_rd, bus.wmask, bus.wvalue);
    assign prmd_wr   = csr_pkg::masked_merge(prmd_rd, bus.wmask, bus.wvalue);
    assign era_wr    = csr_pkg::masked_merge(era_rd, bus.wmask, bus.wvalue);
    assign eentry_wr = csr_pkg::masked_merge(eentry_rd, bus.wmask, bus.wvalue);

    // exception entry beats ertn, both beat a software write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;                  // trap handler runs at plv0
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_wr[csr_pkg::CRMD_PLV +: 2];
            crmd_ie  <= crmd_wr[csr_pkg::CRMD_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv      <= crmd_plv;      // save state for ertn
            prmd_pie       <= crmd_ie;
            era_pc         <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else begin
            if (wr_prmd) begin
                prmd_pplv <= prmd_wr[csr_pkg::PRMD_PPLV +: 2];
                prmd_pie  <= prmd_wr[csr_pkg::PRMD_PIE];
            end
            if (wr_era)
                era_pc <= era_wr;
        end
    end

    assign ex_addr_err = wb_ecode == csr_pkg::ECODE_ADE || wb_ecode == csr_pkg::ECODE_ALE;

    always_ff @(posedge clk) begin
        if (wb_ex && ex_addr_err)
            badv_vaddr <= (wb_ecode == csr_pkg::ECODE_ADE &&
                           wb_esubcode == csr_pkg::ESUBCODE_ADEF) ? wb_pc : wb_vaddr;
    end

    always_ff @(posedge clk) begin
        if (wr_eentry)
            eentry_va <= eentry_wr[31:csr_pkg::EENTRY_VA];
    end

    // da reads 1, pg / datf / datm read 0
    assign crmd_rd   = {23'b0, 2'b00, 2'b00, 1'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_rd   = {29'b0, prmd_pie, prmd_pplv};
    assign estat_rd  = {1'b0, estat_esubcode, estat_ecode, 3'b0, est_is};
    assign era_rd    = era_pc;
    assign badv_rd   = badv_vaddr;
    assign eentry_rd = {eentry_va, 6'b0};  // 64-byte aligned entry

endmodule

/* hdl/csr_timer_int.sv */
// interrupt pending and enable (ECFG, ESTAT.IS), the TCFG/TVAL timer, TICLR and has_int
module csr_timer_int (
    input  logic               clk,
    input  logic               resetn,
    csr_bus_if.target          bus,
    input  logic [7:0]         hw_int_in,
    input  logic               ipi_int_in,
    input  logic               crmd_ie,
    output csr_pkg::int_vec_t  est_is,
    output logic               has_int,
    output csr_pkg::csr_data_t ecfg_rd,
    output csr_pkg::csr_data_t tcfg_rd,
    output csr_pkg::csr_data_t tval_rd
);
    csr_pkg::int_vec_t  ecfg_lie;
    logic [1:0]         is_sw;       // software interrupts
    logic [7:0]         is_hw;
    logic               is_timer;
    logic               is_ipi;
    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [31:csr_pkg::TCFG_INITV] tcfg_initv;
    csr_pkg::csr_data_t timer_cnt;

    csr_pkg::csr_data_t ecfg_wr;
    csr_pkg::csr_data_t estat_wr;
    csr_pkg::csr_data_t tcfg_wr;
    logic               wr_tcfg;
    logic               ticlr_hit;

    assign ecfg_wr  = csr_pkg::masked_merge(ecfg_rd, bus.wmask, bus.wvalue);
    assign estat_wr = csr_pkg::masked_merge({19'b0, est_is}, bus.wmask, bus.wvalue);
    assign tcfg_wr  = csr_pkg::masked_merge(tcfg_rd, bus.wmask, bus.wvalue);  // tcfg after write
    assign wr_tcfg  = bus.we && bus.sel == csr_pkg::SEL_TCFG;
    assign ticlr_hit = bus.we && bus.sel == csr_pkg::SEL_TICLR &&
                       bus.wmask[csr_pkg::TICLR_CLR] && bus.wvalue[csr_pkg::TICLR_CLR];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= '0;
            is_sw    <= '0;
            is_hw    <= '0;
            is_ipi   <= 1'b0;
        end else begin
            if (bus.we && bus.sel == csr_pkg::SEL_ECFG)
                ecfg_lie <= ecfg_wr[12:0] & csr_pkg::ECFG_LIE_MASK;
            if (bus.we && bus.sel == csr_pkg::SEL_ESTAT)
                is_sw <= estat_wr[1:0];
            is_hw  <= hw_int_in;                // sampled every edge
            is_ipi <= ipi_int_in;
        end
    end

    // timer pending, zero count wins over a same-cycle clear
    always_ff @(posedge clk) begin
        if (!resetn)
            is_timer <= 1'b0;
        else if (timer_cnt == '0)
            is_timer <= 1'b1;
        else if (ticlr_hit)
            is_timer <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            tcfg_en <= 1'b0;
        else if (wr_tcfg)
            tcfg_en <= tcfg_wr[csr_pkg::TCFG_EN];
    end

    always_ff @(posedge clk) begin
        if (wr_tcfg) begin
            tcfg_periodic <= tcfg_wr[csr_pkg::TCFG_PERIODIC];
            tcfg_initv    <= tcfg_wr[31:csr_pkg::TCFG_INITV];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            timer_cnt <= csr_pkg::TIMER_IDLE;
        else if (wr_tcfg && tcfg_wr[csr_pkg::TCFG_EN])
            timer_cnt <= {tcfg_wr[31:csr_pkg::TCFG_INITV], 2'b00};  // start at initv*4
        else if (tcfg_en && timer_cnt != csr_pkg::TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initv, 2'b00};
            else
                timer_cnt <= timer_cnt - 32'd1;  // one-shot runs down to idle
        end
    end

    assign est_is  = {is_ipi, is_timer, 1'b0, is_hw, is_sw};
    assign has_int = (est_is & ecfg_lie) != '0 && crmd_ie;
    assign ecfg_rd = {19'b0, ecfg_lie};
    assign tcfg_rd = {tcfg_initv, tcfg_periodic, tcfg_en};
    assign tval_rd = timer_cnt;

endmodule

/* hdl/csr_save_regs.sv */
// four software scratch registers SAVE0 to SAVE3 with masked write
module csr_save_regs (
    input  logic               clk,
    csr_bus_if.target          bus,
    output csr_pkg::csr_data_t save0_rd,
    output csr_pkg::csr_data_t save1_rd,
    output csr_pkg::csr_data_t save2_rd,
    output csr_pkg::csr_data_t save3_rd
);
    csr_pkg::csr_data_t save_q [4];

    // only the addressed word takes the merged value
    always_ff @(posedge clk) begin
        if (bus.we) begin
            case (bus.sel)
                csr_pkg::SEL_SAVE0:
                    save_q[0] <= csr_pkg::masked_merge(save_q[0], bus.wmask, bus.wvalue);
                csr_pkg::SEL_SAVE1:
                    save_q[1] <= csr_pkg::masked_merge(save_q[1], bus.wmask, bus.wvalue);
                csr_pkg::SEL_SAVE2:
                    save_q[2] <= csr_pkg::masked_merge(save_q[2], bus.wmask, bus.wvalue);
                csr_pkg::SEL_SAVE3:
                    save_q[3] <= csr_pkg::masked_merge(save_q[3], bus.wmask, bus.wvalue);
                default: ;                   // other blocks own the rest
            endcase
        end
    end

    assign save0_rd = save_q[0];
    assign save1_rd = save_q[1];
    assign save2_rd = save_q[2];
    assign save3_rd = save_q[3];

endmodule

/* hdl/csr_file.sv */
// CSR file top level with plain access, trap and interrupt ports, connects decoder and blocks
module csr_file (
    input  logic               clk,
    input  logic               resetn,
    // csr instruction access
    input  csr_pkg::csr_num_t  csr_num,
    output csr_pkg::csr_data_t csr_rvalue,
    input  logic               csr_we,
    input  csr_pkg::csr_data_t csr_wmask,
    input  csr_pkg::csr_data_t csr_wvalue,
    // trap from writeback
    input  logic               wb_ex,
    input  csr_pkg::ecode_t    wb_ecode,
    input  csr_pkg::esubcode_t wb_esubcode,
    input  csr_pkg::csr_data_t wb_pc,
    input  csr_pkg::csr_data_t wb_vaddr,
    input  logic               ertn_flush,
    // interrupt sources
    input  logic [7:0]         hw_int_in,
    input  logic               ipi_int_in,
    output logic               has_int
);
    csr_pkg::csr_data_t crmd_rd;
    csr_pkg::csr_data_t prmd_rd;
    csr_pkg::csr_data_t estat_rd;
    csr_pkg::csr_data_t era_rd;
    csr_pkg::csr_data_t badv_rd;
    csr_pkg::csr_data_t eentry_rd;
    csr_pkg::csr_data_t ecfg_rd;
    csr_pkg::csr_data_t tcfg_rd;
    csr_pkg::csr_data_t tval_rd;
    csr_pkg::csr_data_t save0_rd;
    csr_pkg::csr_data_t save1_rd;
    csr_pkg::csr_data_t save2_rd;
    csr_pkg::csr_data_t save3_rd;
    csr_pkg::int_vec_t  est_is;
    logic               crmd_ie;

    csr_bus_if csr_bus ();

    csr_access i_access (
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .crmd_rd    (crmd_rd),
        .prmd_rd    (prmd_rd),
        .estat_rd   (estat_rd),
        .era_rd     (era_rd),
        .badv_rd    (badv_rd),
        .eentry_rd  (eentry_rd),
        .ecfg_rd    (ecfg_rd),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd),
        .save0_rd   (save0_rd),
        .save1_rd   (save1_rd),
        .save2_rd   (save2_rd),
        .save3_rd   (save3_rd),
        .csr_rvalue (csr_rvalue),
        .bus        (csr_bus.decoder)
    );

    csr_trap_regs i_trap_regs (
        .clk         (clk),
        .resetn      (resetn),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .bus         (csr_bus.target),
        .est_is      (est_is),
        .crmd_ie     (crmd_ie),
        .crmd_rd     (crmd_rd),
        .prmd_rd     (prmd_rd),
        .estat_rd    (estat_rd),
        .era_rd      (era_rd),
        .badv_rd     (badv_rd),
        .eentry_rd   (eentry_rd)
    );

    csr_timer_int i_timer_int (
        .clk        (clk),
        .resetn     (resetn),
        .bus        (csr_bus.target),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .crmd_ie    (crmd_ie),
        .est_is     (est_is),
        .has_int    (has_int),
        .ecfg_rd    (ecfg_rd),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd)
    );

    csr_save_regs i_save_regs (
        .clk      (clk),
        .bus      (csr_bus.target),
        .save0_rd (save0_rd),
        .save1_rd (save1_rd),
        .save2_rd (save2_rd),
        .save3_rd (save3_rd)
    );

endmodule

/* bench/csr_file_tb_table.svh */
// stimulus and expected-value table that the CSR file testbench includes in its module
// columns are operation, register number, mask, value, expected value
    function automatic void load_table();
        // state right after reset
        add_entry(OP_RD,   csr_pkg::CSR_CRMD,   32'hffff_ffff, '0, 32'h0000_0008);
        add_entry(OP_RD,   csr_pkg::CSR_ESTAT,  32'h0000_1fff, '0, 32'h0000_0000);
        add_entry(OP_INT,  csr_pkg::CSR_CRMD,   '0,            '0, 32'h0000_0000);
        add_entry(OP_RD,   csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'hffff_ffff);
        // full random write, then a random masked merge, then read back
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE0,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE0,  '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_SAVE0,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE1,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE1,  '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_SAVE1,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE2,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE2,  '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_SAVE2,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE3,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_SAVE3,  '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_SAVE3,  32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_ERA,    32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_ERA,    '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_ERA,    32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_PRMD,   32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_PRMD,   '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_PRMD,   32'h0000_0007, '0, '0);
        add_entry(OP_WR,   csr_pkg::CSR_PRMD,   32'hffff_ffff, 32'hffff_ffff, '0);
        add_entry(OP_RD,   csr_pkg::CSR_PRMD,   32'hffff_ffff, '0, 32'h0000_0007);
        add_entry(OP_WRR,  csr_pkg::CSR_EENTRY, 32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_EENTRY, '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_EENTRY, 32'hffff_ffc0, '0, '0);  // low six bits zero
        add_entry(OP_WR,   csr_pkg::CSR_EENTRY, 32'hffff_ffff, 32'hffff_ffff, '0);
        add_entry(OP_RD,   csr_pkg::CSR_EENTRY, 32'hffff_ffff, '0, 32'hffff_ffc0);
        add_entry(OP_WRR,  csr_pkg::CSR_ECFG,   32'hffff_ffff, '0, '0);
        add_entry(OP_WRR,  csr_pkg::CSR_ECFG,   '0,            '0, '0);
        add_entry(OP_RDS,  csr_pkg::CSR_ECFG,   32'h0000_1bff, '0, '0);  // bit 10 and 31:13 zero
        add_entry(OP_WR,   csr_pkg::CSR_ECFG,   32'hffff_ffff, 32'hffff_ffff, '0);
        add_entry(OP_RD,   csr_pkg::CSR_ECFG,   32'hffff_ffff, '0, 32'h0000_1bff);
        add_entry(OP_RD,   csr_pkg::CSR_TICLR,  32'hffff_ffff, '0, 32'h0000_0000);
        add_entry(OP_RD,   14'h3ff,             32'hffff_ffff, '0, 32'h0000_0000);
        // exception entry from plv 3 with ie set, then ertn
        add_entry(OP_WR,   csr_pkg::CSR_CRMD,   32'hffff_ffff, 32'h0000_0007, '0);
        add_entry(OP_RD,   csr_pkg::CSR_CRMD,   32'hffff_ffff, '0, 32'h0000_000f);
        add_entry(OP_EX,   csr_pkg::CSR_CRMD,   32'h0000_0008, 32'h1c00_0a40, 32'h0000_beef);
        add_entry(OP_RD,   csr_pkg::CSR_CRMD,   32'hffff_ffff, '0, 32'h0000_0008);
        add_entry(OP_RD,   csr_pkg::CSR_PRMD,   32'hffff_ffff, '0, 32'h0000_0007);
        add_entry(OP_RD,   csr_pkg::CSR_ERA,    32'hffff_ffff, '0, 32'h1c00_0a40);
        add_entry(OP_RD,   csr_pkg::CSR_ESTAT,  32'h7fff_0000, '0, 32'h0008_0000);
        add_entry(OP_RD,   csr_pkg::CSR_BADV,   32'hffff_ffff, '0, 32'h1c00_0a40);  // fetch error
        add_entry(OP_ERTN, csr_pkg::CSR_CRMD,   '0,            '0, '0);
        add_entry(OP_RD,   csr_pkg::CSR_CRMD,   32'hffff_ffff, '0, 32'h0000_000f);
        add_entry(OP_EX,   csr_pkg::CSR_CRMD,   32'h0000_0009, 32'h1c00_0b00, 32'h8000_1236);
        add_entry(OP_RD,   csr_pkg::CSR_BADV,   32'hffff_ffff, '0, 32'h8000_1236);
        add_entry(OP_EX,   csr_pkg::CSR_CRMD,   32'h0000_004b, 32'h1c00_0c00, 32'h1111_1111);
        add_entry(OP_RD,   csr_pkg::CSR_BADV,   32'hffff_ffff, '0, 32'h8000_1236);  // kept
        add_entry(OP_RD,   csr_pkg::CSR_ESTAT,  32'h7fff_0000, '0, 32'h004b_0000);
        add_entry(OP_RD,   csr_pkg::CSR_ERA,    32'hffff_ffff, '0, 32'h1c00_0c00);
        // software interrupt gated by crmd ie, then sampled hw lines
        add_entry(OP_WR,   csr_pkg::CSR_ECFG,   32'hffff_ffff, 32'h0000_0001, '0);
        add_entry(OP_WR,   csr_pkg::CSR_ESTAT,  32'h0000_0003, 32'h0000_0001, '0);
        add_entry(OP_INT,  csr_pkg::CSR_ESTAT,  '0,            '0, 32'h0000_0000);
        add_entry(OP_WR,   csr_pkg::CSR_CRMD,   32'h0000_0004, 32'h0000_0004, '0);
        add_entry(OP_INT,  csr_pkg::CSR_ESTAT,  '0,            '0, 32'h0000_0001);
        add_entry(OP_WR,   csr_pkg::CSR_CRMD,   32'h0000_0004, 32'h0000_0000, '0);
        add_entry(OP_INT,  csr_pkg::CSR_ESTAT,  '0,            '0, 32'h0000_0000);
        add_entry(OP_WR,   csr_pkg::CSR_ESTAT,  32'h0000_0003, 32'h0000_0000, '0);
        add_entry(OP_HW,   csr_pkg::CSR_ESTAT,  32'h0000_13fc, 32'h0000_01a5, 32'h0000_0000);
        add_entry(OP_RD,   csr_pkg::CSR_ESTAT,  32'h0000_13fc, '0, 32'h0000_1294);
        // one-shot timer with initv 5, then periodic
        add_entry(OP_WR,   csr_pkg::CSR_ECFG,   32'hffff_ffff, 32'h0000_0800, '0);
        add_entry(OP_WR,   csr_pkg::CSR_CRMD,   32'h0000_0004, 32'h0000_0004, '0);
        add_entry(OP_WR,   csr_pkg::CSR_TCFG,   32'hffff_ffff, 32'h0000_0015, '0);
        add_entry(OP_RD,   csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'h0000_0014);
        add_entry(OP_RD,   csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'h0000_0013);
        add_entry(OP_INT,  csr_pkg::CSR_TVAL,   '0,            '0, 32'h0000_0000);
        add_entry(OP_WAIT, csr_pkg::CSR_ESTAT,  32'h0000_0800, '0, 32'h0000_0800);
        add_entry(OP_INT,  csr_pkg::CSR_ESTAT,  '0,            '0, 32'h0000_0001);
        add_entry(OP_WR,   csr_pkg::CSR_TICLR,  32'h0000_0001, 32'h0000_0001, '0);
        add_entry(OP_RD,   csr_pkg::CSR_ESTAT,  32'h0000_0800, '0, 32'h0000_0000);
        add_entry(OP_INT,  csr_pkg::CSR_ESTAT,  '0,            '0, 32'h0000_0000);
        add_entry(OP_RD,   csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'hffff_ffff);
        add_entry(OP_WR,   csr_pkg::CSR_TCFG,   32'hffff_ffff, 32'h0000_0017, '0);
        add_entry(OP_RD,   csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'h0000_0014);
        add_entry(OP_RD,   csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'h0000_0013);
        add_entry(OP_RD,   csr_pkg::CSR_TCFG,   32'hffff_ffff, '0, 32'h0000_0017);
        add_entry(OP_WAIT, csr_pkg::CSR_TVAL,   32'hffff_ffff, '0, 32'h0000_0014);  // reload
    endfunction

/* bench/csr_file_tb.sv */
// testbench that runs the stimulus table against csr_file and checks every read
module csr_file_tb;

    typedef enum logic [3:0] {
        OP_WR,    // masked write from the table
        OP_WRR,   // random value and mask with the table mask bits forced on
        OP_RD,    // csr_rvalue masked must equal exp_val
        OP_RDS,   // csr_rvalue must equal the shadow word masked
        OP_INT,   // has_int must equal exp_val bit 0
        OP_EX,    // wb_ex pulse with codes in mask, pc in value, vaddr in exp_val
        OP_ERTN,
        OP_HW,    // value bits 7:0 to hw_int_in and bit 8 to ipi_int_in, read checked as OP_RD
        OP_WAIT   // poll until csr_rvalue masked equals exp_val
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [13:0] num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] exp_val;
    } entry_t;

    localparam int WAIT_LIMIT = 400;  // cycles per poll

    logic                   clk;
    logic                   resetn;
    csr_pkg::csr_num_t      csr_num;
    csr_pkg::csr_data_t     csr_rvalue;
    logic                   csr_we;
    csr_pkg::csr_data_t     csr_wmask;
    csr_pkg::csr_data_t     csr_wvalue;
    logic                   wb_ex;
    csr_pkg::ecode_t        wb_ecode;
    csr_pkg::esubcode_t     wb_esubcode;
    csr_pkg::csr_data_t     wb_pc;
    csr_pkg::csr_data_t     wb_vaddr;
    logic                   ertn_flush;
    logic [7:0]             hw_int_in;
    logic                   ipi_int_in;
    logic                   has_int;

    integer                 seed;
    entry_t                 ops [$];
    logic [31:0]            shadow [0:16383];  // software view of each written register

    csr_file i_csr_file (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (csr_num),
        .csr_rvalue  (csr_rvalue),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .has_int     (has_int)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
        if (got !== exp_val)
            stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp_val));
    endtask

    function automatic void add_entry(input op_t op, input logic [13:0] num,
                                      input logic [31:0] mask, input logic [31:0] value,
                                      input logic [31:0] exp_val);
        ops.push_back('{op, num, mask, value, exp_val});
    endfunction

    `include "csr_file_tb_table.svh"

    // drives one table entry per rising edge and checks at the falling edge
    task automatic run_entry(input entry_t e);
        logic [31:0] m;
        logic [31:0] v;
        int          waited;
        @(posedge clk);
        csr_we     <= 1'b0;  // pulses last one cycle
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
        csr_num    <= e.num;
        case (e.op)
            OP_WR, OP_WRR: begin
                m = e.mask;
                v = e.value;
                if (e.op == OP_WRR) begin
                    m = $random(seed) | e.mask;
                    v = $random(seed);
                end
                csr_we     <= 1'b1;
                csr_wmask  <= m;
                csr_wvalue <= v;
                shadow[e.num] = (m & v) | (~m & shadow[e.num]);  // masked bits take the value
            end
            OP_EX: begin
                wb_ex       <= 1'b1;
                wb_ecode    <= e.mask[5:0];
                wb_esubcode <= e.mask[14:6];
                wb_pc       <= e.value;
                wb_vaddr    <= e.exp_val;
            end
            OP_ERTN: ertn_flush <= 1'b1;
            OP_HW: begin
                hw_int_in  <= e.value[7:0];
                ipi_int_in <= e.value[8];
            end
            default: ;
        endcase
        @(negedge clk);
        waited = 0;
        case (e.op)
            OP_RD, OP_HW: check_value("csr_rvalue", csr_rvalue & e.mask, e.exp_val);
            OP_RDS: check_value("csr_rvalue", csr_rvalue, shadow[e.num] & e.mask);
            OP_INT: check_value("has_int", {31'b0, has_int}, e.exp_val);
            OP_WAIT: begin
                while ((csr_rvalue & e.mask) !== e.exp_val) begin
                    if (waited == WAIT_LIMIT)
                        stop_with_error($sformatf("timed out waiting for csr %h to reach %h",
                                                  e.num, e.exp_val));
                    else begin
                        waited++;
                        @(negedge clk);
                    end
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        seed = 80463;
        clk = 1'b0;
        resetn      <= 1'b0;
        csr_num     <= '0;
        csr_we      <= 1'b0;
        csr_wmask   <= '0;
        csr_wvalue  <= '0;
        wb_ex       <= 1'b0;
        wb_ecode    <= '0;
        wb_esubcode <= '0;
        wb_pc       <= '0;
        wb_vaddr    <= '0;
        ertn_flush  <= 1'b0;
        hw_int_in   <= '0;
        ipi_int_in  <= 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        foreach (ops[i])
            run_entry(ops[i]);
        $display("sim passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+bench
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access.sv
hdl/csr_trap_regs.sv
hdl/csr_timer_int.sv
hdl/csr_save_regs.sv
hdl/csr_file.sv
bench/csr_file_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the CSR file testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module csr_file_tb -f verilog.f -o csr_file_sim
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/csr_file_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
